// File: source/debug_print_pkg.sv
// Shared types for the debug print channel.
package debug_print_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request encoding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Selects how much of the value goes out on the line.
    typedef enum logic {
        print_byte = 1'b0,  // Bits 7:0 only.
        print_word = 1'b1   // All four bytes, most significant first.
    } print_kind_e;

    // One print request as seen by the serializer.
    typedef struct packed {
        print_kind_e kind;
        logic [31:0] data;
    } print_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Number of bytes sent for a word print.
    localparam int BYTES_PER_WORD = 4;

endpackage

// File: source/print_serializer.sv
`timescale 1ns/1ps

module print_serializer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,
    input  debug_print_pkg::print_req_t req_info,
    input  logic                        tx_rdy,
    output logic                        tx_vld,
    output logic [7:0]                  tx_byte,
    output logic                        ack,
    output logic                        busy
);

    // Wide enough to hold a full word count.
    localparam int CNT_W = $clog2(debug_print_pkg::BYTES_PER_WORD + 1);

    typedef enum logic [1:0] {
        idle,
        send,
        wait_frame,
        done
    } state_e;

    state_e                      state;
    logic                        req_q;
    logic                        req_rise;
    debug_print_pkg::print_req_t cap;
    logic [CNT_W-1:0]            byte_cnt;  // Bytes still to hand to the transmitter.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req;
        end
    end

    assign req_rise = req & ~req_q;

    // The value is frozen here so later input changes cannot leak into the print.
    always_ff @(posedge clk) begin
        if (state == idle && req_rise) begin
            cap <= req_info;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (req_rise) begin
                        state <= send;
                        if (req_info.kind == debug_print_pkg::print_word) begin
                            byte_cnt <= CNT_W'(debug_print_pkg::BYTES_PER_WORD);
                        end else begin
                            byte_cnt <= CNT_W'(1);
                        end
                    end
                end
                send: begin
                    if (tx_rdy) begin  // Byte is taken in this cycle.
                        state    <= wait_frame;
                        byte_cnt <= byte_cnt - 1'b1;
                    end
                end
                wait_frame: begin
                    // The transmitter drops ready one cycle after the strobe.
                    if (!tx_rdy) begin
                        state <= (byte_cnt == '0) ? done : send;
                    end
                end
                done: begin
                    if (tx_rdy) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign tx_vld = (state == send) && tx_rdy;
    assign ack    = (state == done) && tx_rdy;  // Last frame has left the line.
    assign busy   = (state != idle);

    // Count n selects byte n-1, so the highest byte goes first.
    always_comb begin
        tx_byte = cap.data[7:0];
        if (cap.kind == debug_print_pkg::print_word) begin
            for (int i = 0; i < debug_print_pkg::BYTES_PER_WORD; i++) begin
                if (byte_cnt == CNT_W'(i + 1)) begin
                    tx_byte = cap.data[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_vld,
    input  logic [7:0] tx_byte,
    output logic       tx_rdy,
    output logic       txd
);

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int FRAME_BITS = 10;  // Start, eight data, stop.

    logic [FRAME_BITS-1:0] frame;
    logic [BAUD_W-1:0]     baud_cnt;
    logic [3:0]            bit_cnt;
    logic                  active;
    logic                  bit_end;

    assign bit_end = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame shifter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame    <= '1;  // Line idles high.
            baud_cnt <= '0;
            bit_cnt  <= '0;
            active   <= 1'b0;
        end else if (!active) begin
            if (tx_vld) begin
                // Bit 0 goes out first, so the start bit sits at the bottom.
                frame    <= {1'b1, tx_byte, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
                active   <= 1'b1;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[FRAME_BITS-1:1]};  // Ones fill in behind the stop bit.
            if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                active <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign tx_rdy = ~active;
    assign txd    = frame[0];

endmodule

// File: source/debug_print_top.sv
`timescale 1ns/1ps

module debug_print_top #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req,
    input  debug_print_pkg::print_kind_e kind,
    input  logic [31:0]                  data,
    output logic                         txd,
    output logic                         ack,
    output logic                         busy
);

    debug_print_pkg::print_req_t req_info;
    logic                        tx_vld;
    logic [7:0]                  tx_byte;
    logic                        tx_rdy;

    assign req_info = '{kind: kind, data: data};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request to byte stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    print_serializer print_serializer_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_info (req_info),
        .tx_rdy   (tx_rdy),
        .tx_vld   (tx_vld),
        .tx_byte  (tx_byte),
        .ack      (ack),
        .busy     (busy)
    );

    // Byte stream to serial line.
    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_tx_inst (
        .clk     (clk),
        .rst     (rst),
        .tx_vld  (tx_vld),
        .tx_byte (tx_byte),
        .tx_rdy  (tx_rdy),
        .txd     (txd)
    );

endmodule

// File: tb/debug_print_properties.sv
`timescale 1ns/1ps

module debug_print_properties (
    input logic clk,
    input logic rst,
    input logic ack,
    input logic busy,
    input logic txd,
    input logic tx_vld,
    input logic tx_rdy
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serializer and line rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack stayed high for two cycles");

    // The transmitter takes the byte, so ready drops on the next cycle.
    vld_needs_rdy: assert property (@(posedge clk) disable iff (rst)
                                    tx_vld |-> tx_rdy ##1 !tx_rdy)
        else $error("tx_vld without a ready transmitter that took the byte");

    // An idle channel leaves the line in its mark state.
    idle_line_high: assert property (@(posedge clk) disable iff (rst) !busy |-> txd)
        else $error("txd low while busy is low");

endmodule

bind debug_print_top debug_print_properties debug_print_properties_inst (
    .clk    (clk),
    .rst    (rst),
    .ack    (ack),
    .busy   (busy),
    .txd    (txd),
    .tx_vld (tx_vld),
    .tx_rdy (tx_rdy)
);

// File: tb/debug_print_tb.sv
`timescale 1ns/1ps

module debug_print_tb;

    localparam int CLKS_PER_BIT  = 4;
    localparam int LINE_TIMEOUT  = 20 * CLKS_PER_BIT;  // Cycles allowed before a frame or ack.
    localparam int PRINT_TIMEOUT = 60 * CLKS_PER_BIT;  // Longer than a whole word print.

    logic                         clk;
    logic                         rst;
    logic                         req;
    debug_print_pkg::print_kind_e kind;
    logic [31:0]                  data;
    logic                         txd;
    logic                         ack;
    logic                         busy;

    integer     seed;
    int         errors;
    int         pass_count;
    int         fail_count;
    int         ack_count = 0;
    logic [7:0] rx_bytes [$];

    debug_print_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) debug_print_top_inst (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .kind (kind),
        .data (data),
        .txd  (txd),
        .ack  (ack),
        .busy (busy)
    );

    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (!rst && ack) begin
            ack_count <= ack_count + 1;  // One count per ack pulse.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and waiting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_busy_low(input string where);
        int t = 0;
        while (busy !== 1'b0 && t < PRINT_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (busy !== 1'b0) begin
            $display("Timeout at %0t ns, busy never fell %s", $time, where);
            errors++;
        end
    endtask

    task automatic wait_ack(input int ack_before);
        int t = 0;
        while (ack_count == ack_before && t < LINE_TIMEOUT) begin
            @(negedge clk);
            check_value("txd before ack", 32'd1, 32'(txd));  // No further frame may start.
            t++;
        end
        if (ack_count == ack_before) begin
            $display("Timeout at %0t ns, ack never came after the last frame", $time);
            errors++;
        end
    endtask

    // Decodes 8N1 frames from txd, sampling each bit near its middle.
    task automatic receive_bytes(input int count);
        int         t;
        logic [7:0] b;
        for (int f = 0; f < count; f++) begin
            t = 0;
            while (txd !== 1'b0 && t < LINE_TIMEOUT) begin
                @(negedge clk);
                t++;
            end
            if (txd !== 1'b0) begin
                $display("Timeout at %0t ns, frame %0d never started on txd", $time, f);
                errors++;
                return;
            end
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_value("txd start bit", 32'd0, 32'(txd));
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[i] = txd;  // Least significant bit arrives first.
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_value("txd stop bit", 32'd1, 32'(txd));
            rx_bytes.push_back(b);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_request(input debug_print_pkg::print_kind_e k,
                                 input logic [31:0] value, input logic second);
        logic [31:0] rnd;
        int          offset;
        kind = k;
        data = value;
        req  = 1'b1;
        repeat (2) @(negedge clk);
        check_value("busy", 32'd1, 32'(busy));
        req  = 1'b0;
        rnd  = $random(seed);
        kind = debug_print_pkg::print_kind_e'(rnd[0]);
        data = $random(seed);  // The captured copy must not follow this.
        if (second) begin
            rnd    = $random(seed);
            offset = 1 + int'(rnd[3:0]);
            repeat (offset) @(negedge clk);
            check_value("busy", 32'd1, 32'(busy));
            req  = 1'b1;
            data = $random(seed);
            repeat (2) @(negedge clk);
            req  = 1'b0;
        end
    endtask

    task automatic run_case(input int idx, input debug_print_pkg::print_kind_e k,
                            input logic [31:0] value, input int gap, input int second);
        int         n_exp;
        int         err_before;
        int         ack_before;
        logic [7:0] exp_byte;
        wait_busy_low("before the request");
        repeat (gap) @(negedge clk);
        n_exp = (k == debug_print_pkg::print_word) ? debug_print_pkg::BYTES_PER_WORD : 1;
        err_before = errors;
        ack_before = ack_count;
        rx_bytes.delete();
        fork
            drive_request(k, value, second != 0);
            receive_bytes(n_exp);
        join
        wait_ack(ack_before);
        wait_busy_low("after ack");
        check_value("ack count", 32'd1, 32'(ack_count - ack_before));
        check_value("frame count", 32'(n_exp), 32'(rx_bytes.size()));
        // Highest byte first, a byte print carries only bits 7:0.
        for (int i = 0; i < n_exp && i < int'(rx_bytes.size()); i++) begin
            exp_byte = value[8*(n_exp-1-i) +: 8];
            check_value($sformatf("byte %0d", i), 32'(exp_byte), 32'(rx_bytes[i]));
        end
        if (errors == err_before) begin
            pass_count++;
            $display("case %0d ok     %s %h gap %0d second %0d", idx, k.name(), value, gap,
                     second);
        end else begin
            fail_count++;
            $display("case %0d FAILED %s %h gap %0d second %0d", idx, k.name(), value, gap,
                     second);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          fd;
        int          rc;
        int          idx;
        int          gap;
        int          second;
        logic [31:0] kind_raw;
        logic [31:0] value;
        string       line;

        seed       = 32'h6884;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        idx        = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        req        = 1'b0;
        kind       = debug_print_pkg::print_byte;
        data       = 32'd0;

        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("txd", 32'd1, 32'(txd));
            check_value("ack", 32'd0, 32'(ack));
            check_value("busy", 32'd0, 32'(busy));
        end

        fd = $fopen("tb/print_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file tb/print_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0) begin
                    // Comment and blank lines do not match all four fields.
                    if ($sscanf(line, "%h %h %d %d", kind_raw, value, gap, second) == 4) begin
                        run_case(idx, debug_print_pkg::print_kind_e'(kind_raw[0]), value,
                                 gap, second);
                        idx++;
                    end
                end
            end
            $fclose(fd);
        end
        if (idx == 0) begin
            $display("No cases were read from the case file");
            errors++;
        end

        // Nothing may follow the last print.
        repeat (12 * CLKS_PER_BIT) begin
            @(negedge clk);
            check_value("txd", 32'd1, 32'(txd));
            check_value("busy", 32'd0, 32'(busy));
        end
        check_value("total ack count", 32'(idx), 32'(ack_count));

        $display("%0d cases passed, %0d cases failed, %0d checks failed", pass_count,
                 fail_count, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/print_cases.txt
# kind (0 byte, 1 word)   value (hex)   idle gap in cycles   second edge while busy (0 or 1)
# Every case also changes kind and data on the inputs once the request is taken.
0 000000a5 3 0
1 deadbeef 0 0
1 12345678 0 1
0 0000ff3c 5 1
0 80000001 0 0
1 00000000 2 0
1 ffffffff 0 0
0 7e7e7e00 1 1
1 a5c3e10f 0 1
0 00000055 0 0
0 fedcba98 0 1
1 01020304 7 0
1 80808080 0 1
0 000000ff 0 0
1 0f1e2d3c 4 0
0 12345601 0 0

// File: debug_print_top.f
source/debug_print_pkg.sv
source/print_serializer.sv
source/uart_tx.sv
source/debug_print_top.sv
tb/debug_print_properties.sv
tb/debug_print_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the debug print testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module debug_print_tb \
    -f debug_print_top.f

sim_status=0
./obj_dir/Vdebug_print_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Regression failed" sim.log || [ "$sim_status" -ne 0 ]; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished, see sim.log"
